//--- hw/mem_req_pkg.sv
package mem_req_pkg;

    // access size, same coding as the axi size field for 8/16/32 bits
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_e;

    typedef struct packed {
        logic        req;
        logic        wr;
        size_e       size;
        logic [31:0] addr;
        logic [31:0] wdata;
        // beats minus one
        logic [3:0]  len;
    } sram_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        // set on the final data_ok of a transaction
        logic        last;
        logic [31:0] rdata;
    } sram_rsp_t;

    // request tagged with the id of the requester that owns it
    typedef struct packed {
        sram_req_t  cmd;
        logic [3:0] id;
    } bus_req_t;

endpackage

//--- hw/axi_pkg.sv
package axi_pkg;

    localparam logic [1:0] burst_incr = 2'b01;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic        valid;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic        valid;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
        logic        valid;
    } axi_w_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic        last;
        logic        valid;
    } axi_r_t;

    typedef struct packed {
        logic [3:0] id;
        logic       valid;
    } axi_b_t;

endpackage

//--- hw/sramlike_arbiter.sv
module sramlike_arbiter #(
    parameter logic [3:0] INST_ID = 4'd0,
    parameter logic [3:0] DATA_ID = 4'd1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_req_pkg::sram_req_t inst_req,
    input  mem_req_pkg::sram_req_t data_req,
    output mem_req_pkg::sram_rsp_t inst_rsp,
    output mem_req_pkg::sram_rsp_t data_rsp,
    output mem_req_pkg::bus_req_t  bus_req,
    input  mem_req_pkg::sram_rsp_t bus_rsp
);

    logic owner_valid;
    // 0 = instruction port, 1 = data port
    // kept after release, so it also names the last winner
    logic owner_data;
    logic grant_data;
    logic txn_end;

    // data wins if alone, or on a tie when inst won last time
    assign grant_data = data_req.req && (!inst_req.req || !owner_data);
    assign txn_end    = bus_rsp.data_ok && bus_rsp.last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_valid <= 1'b0;
            owner_data  <= 1'b0;
        end else if (owner_valid) begin
            if (txn_end) begin
                owner_valid <= 1'b0;
            end
        end else if (inst_req.req || data_req.req) begin
            owner_valid <= 1'b1;
            owner_data  <= grant_data;
        end
    end

    always_comb begin
        bus_req = '0;
        if (owner_valid) begin
            bus_req.cmd = owner_data ? data_req : inst_req;
            bus_req.id  = owner_data ? DATA_ID : INST_ID;
        end
    end

    // response flags reach the owner only, read data goes to both
    always_comb begin
        inst_rsp = bus_rsp;
        data_rsp = bus_rsp;
        if (!(owner_valid && !owner_data)) begin
            inst_rsp.addr_ok = 1'b0;
            inst_rsp.data_ok = 1'b0;
            inst_rsp.last    = 1'b0;
        end
        if (!(owner_valid && owner_data)) begin
            data_rsp.addr_ok = 1'b0;
            data_rsp.data_ok = 1'b0;
            data_rsp.last    = 1'b0;
        end
    end

endmodule

//--- hw/sramlike_to_axi.sv
module sramlike_to_axi (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_req_pkg::bus_req_t  bus_req,
    output mem_req_pkg::sram_rsp_t bus_rsp,
    output axi_pkg::axi_ar_t       ar,
    input  logic                   arready,
    input  axi_pkg::axi_r_t        r,
    output logic                   rready,
    output axi_pkg::axi_aw_t       aw,
    input  logic                   awready,
    output axi_pkg::axi_w_t        w,
    input  logic                   wready,
    input  axi_pkg::axi_b_t        b,
    output logic                   bready
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_rdata,
        st_wresp
    } state_e;

    state_e     state;
    state_e     state_nxt;
    logic       aw_done;
    logic       w_done;
    logic       ar_fire;
    logic       aw_fire;
    logic       w_fire;
    logic       wr_accepted;
    logic [3:0] strb;

    // byte lanes from size and low address bits
    always_comb begin
        strb = 4'b1111;
        case (bus_req.cmd.size)
            mem_req_pkg::size_byte: strb = 4'b0001 << bus_req.cmd.addr[1:0];
            mem_req_pkg::size_half: begin
                if (bus_req.cmd.addr[1:0] == 2'd0) begin
                    strb = 4'b0011;
                end else if (bus_req.cmd.addr[1:0] == 2'd2) begin
                    strb = 4'b1100;
                end
            end
            default: strb = 4'b1111;
        endcase
    end

    always_comb begin
        ar.id    = bus_req.id;
        ar.addr  = bus_req.cmd.addr;
        ar.len   = {4'd0, bus_req.cmd.len};
        ar.size  = {1'b0, bus_req.cmd.size};
        ar.burst = axi_pkg::burst_incr;
        ar.valid = (state == st_addr) && !bus_req.cmd.wr;
    end

    always_comb begin
        aw.id    = bus_req.id;
        aw.addr  = bus_req.cmd.addr;
        aw.len   = {4'd0, bus_req.cmd.len};
        aw.size  = {1'b0, bus_req.cmd.size};
        aw.burst = axi_pkg::burst_incr;
        aw.valid = (state == st_addr) && bus_req.cmd.wr && !aw_done;
    end

    // writes are single beat, data already sits on its lanes
    always_comb begin
        w.data  = bus_req.cmd.wdata;
        w.strb  = strb;
        w.last  = 1'b1;
        w.valid = (state == st_addr) && bus_req.cmd.wr && !w_done;
    end

    assign ar_fire     = ar.valid && arready;
    assign aw_fire     = aw.valid && awready;
    assign w_fire      = w.valid && wready;
    assign wr_accepted = (aw_done || aw_fire) && (w_done || w_fire);

    assign rready = (state == st_rdata);
    assign bready = (state == st_wresp);

    always_comb begin
        bus_rsp.addr_ok = 1'b0;
        bus_rsp.data_ok = 1'b0;
        bus_rsp.last    = 1'b0;
        bus_rsp.rdata   = r.data;
        case (state)
            st_addr: bus_rsp.addr_ok = bus_req.cmd.wr ? wr_accepted : ar_fire;
            st_rdata: begin
                bus_rsp.data_ok = r.valid;
                bus_rsp.last    = r.valid && r.last;
            end
            st_wresp: begin
                bus_rsp.data_ok = b.valid;
                bus_rsp.last    = b.valid;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (bus_req.cmd.req) state_nxt = st_addr;
            st_addr: begin
                if (bus_req.cmd.wr && wr_accepted) begin
                    state_nxt = st_wresp;
                end else if (ar_fire) begin
                    state_nxt = st_rdata;
                end
            end
            st_rdata: if (r.valid && r.last) state_nxt = st_idle;
            st_wresp: if (b.valid) state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // aw and w may be accepted in different cycles
            if (state != st_addr || state_nxt != st_addr) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                aw_done <= aw_done || aw_fire;
                w_done  <= w_done || w_fire;
            end
        end
    end

endmodule

//--- hw/axi_sram.sv
module axi_sram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst_n,
    input  axi_pkg::axi_ar_t ar,
    output logic             arready,
    output axi_pkg::axi_r_t  r,
    input  logic             rready,
    input  axi_pkg::axi_aw_t aw,
    output logic             awready,
    input  axi_pkg::axi_w_t  w,
    output logic             wready,
    output axi_pkg::axi_b_t  b,
    input  logic             bready
);

    localparam int idx_w = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_wdata,
        st_bresp
    } state_e;

    state_e           state;
    logic [31:0]      mem [MEM_WORDS];
    logic [29:0]      word_addr;
    logic [7:0]       beat_cnt;
    logic [7:0]       beat_len;
    logic [3:0]       txn_id;
    logic [idx_w-1:0] idx;
    logic             last_beat;

    // word index wraps at the memory depth
    assign idx       = idx_w'(word_addr % MEM_WORDS);
    assign last_beat = (beat_cnt == beat_len);

    // reads take priority if both address channels are valid
    assign arready = (state == st_idle);
    assign awready = (state == st_idle) && !ar.valid;
    assign wready  = (state == st_wdata);

    always_comb begin
        r.id    = txn_id;
        r.data  = mem[idx];
        r.last  = last_beat;
        r.valid = (state == st_read);
    end

    always_comb begin
        b.id    = txn_id;
        b.valid = (state == st_bresp);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (ar.valid) begin
                        state <= st_read;
                    end else if (aw.valid) begin
                        state <= st_wdata;
                    end
                end
                st_read: if (rready && last_beat) state <= st_idle;
                st_wdata: if (w.valid) state <= st_bresp;
                st_bresp: if (bready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // burst tracking and memory contents
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            if (ar.valid) begin
                txn_id    <= ar.id;
                word_addr <= ar.addr[31:2];
                beat_len  <= ar.len;
                beat_cnt  <= 8'd0;
            end else if (aw.valid) begin
                txn_id    <= aw.id;
                word_addr <= aw.addr[31:2];
            end
        end
        if (state == st_read && rready && !last_beat) begin
            beat_cnt  <= beat_cnt + 8'd1;
            word_addr <= word_addr + 30'd1;
        end
        if (state == st_wdata && w.valid) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- hw/cpu_axi_subsys.sv
module cpu_axi_subsys #(
    parameter int         MEM_WORDS = 1024,
    parameter logic [3:0] INST_ID   = 4'd0,
    parameter logic [3:0] DATA_ID   = 4'd1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_req_pkg::sram_req_t inst_req,
    input  mem_req_pkg::sram_req_t data_req,
    output mem_req_pkg::sram_rsp_t inst_rsp,
    output mem_req_pkg::sram_rsp_t data_rsp
);

    mem_req_pkg::bus_req_t  bus_req;
    mem_req_pkg::sram_rsp_t bus_rsp;

    axi_pkg::axi_ar_t ar;
    axi_pkg::axi_aw_t aw;
    axi_pkg::axi_w_t  w;
    axi_pkg::axi_r_t  r;
    axi_pkg::axi_b_t  b;
    logic             arready;
    logic             awready;
    logic             wready;
    logic             rready;
    logic             bready;

    sramlike_arbiter #(
        .INST_ID(INST_ID),
        .DATA_ID(DATA_ID)
    ) arbiter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_req(inst_req),
        .data_req(data_req),
        .inst_rsp(inst_rsp),
        .data_rsp(data_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    sramlike_to_axi bridge_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp),
        .ar     (ar),
        .arready(arready),
        .r      (r),
        .rready (rready),
        .aw     (aw),
        .awready(awready),
        .w      (w),
        .wready (wready),
        .b      (b),
        .bready (bready)
    );

    axi_sram #(
        .MEM_WORDS(MEM_WORDS)
    ) sram_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .ar     (ar),
        .arready(arready),
        .r      (r),
        .rready (rready),
        .aw     (aw),
        .awready(awready),
        .w      (w),
        .wready (wready),
        .b      (b),
        .bready (bready)
    );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- tb/cpu_axi_subsys_tb.sv
module cpu_axi_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_words = 1024;
    localparam logic [31:0] rand_base = 32'h0000_0200;
    // 2 + 5 + 9 + 3 + 60 transactions over the five tests
    localparam int num_txns = 79;
    localparam int watchdog_cycles = num_txns * 64 + 5;

    logic                   clk;
    logic                   rst_n;
    mem_req_pkg::sram_req_t inst_req;
    mem_req_pkg::sram_req_t data_req;
    mem_req_pkg::sram_rsp_t inst_rsp;
    mem_req_pkg::sram_rsp_t data_rsp;

    logic [31:0] ref_mem [mem_words];
    int          seed = 40;
    int          inst_beats = 0;
    int          data_beats = 0;
    int          grant_log [$];
    logic        last_winner_data = 1'b0;

    tb_clock_gen clock_gen_inst (
        .clk(clk)
    );

    cpu_axi_subsys cpu_axi_subsys_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_req(inst_req),
        .data_req(data_req),
        .inst_rsp(inst_rsp),
        .data_rsp(data_rsp)
    );

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int model_index(input logic [31:0] a);
        return int'((a >> 2) % 32'(mem_words));
    endfunction

    // byte lanes touched by an access
    function automatic logic [3:0] lane_mask(input mem_req_pkg::size_e size,
                                             input logic [1:0] offset);
        if (size == mem_req_pkg::size_byte) begin
            return 4'b0001 << offset;
        end else if (size == mem_req_pkg::size_half && offset == 2'd0) begin
            return 4'b0011;
        end else if (size == mem_req_pkg::size_half && offset == 2'd2) begin
            return 4'b1100;
        end
        return 4'b1111;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic void model_write(input mem_req_pkg::size_e size,
                                        input logic [31:0] addr, input logic [31:0] wdata);
        logic [3:0] mask;
        mask = lane_mask(size, addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                ref_mem[model_index(addr)][8*i +: 8] = wdata[8*i +: 8];
            end
        end
    endfunction

    // counts beats and grant order seen on each port
    always @(negedge clk) begin
        if (rst_n) begin
            if (inst_rsp.data_ok) inst_beats++;
            if (data_rsp.data_ok) data_beats++;
            if (inst_rsp.addr_ok) grant_log.push_back(0);
            if (data_rsp.addr_ok) grant_log.push_back(1);
        end
    end

    task automatic check_flags_low(input string what);
        check_eq({29'd0, inst_rsp.addr_ok, inst_rsp.data_ok, inst_rsp.last}, 32'd0, what);
        check_eq({29'd0, data_rsp.addr_ok, data_rsp.data_ok, data_rsp.last}, 32'd0, what);
    endtask

    // one single-beat data access, starts and ends 2 ns after a rising edge
    task automatic data_access(input logic wr, input mem_req_pkg::size_e size,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        logic got_addr;
        logic got_last;
        int   beats;
        got_addr = 1'b0;
        got_last = 1'b0;
        beats    = 0;
        rdata    = '0;
        data_req.req   = 1'b1;
        data_req.wr    = wr;
        data_req.size  = size;
        data_req.addr  = addr;
        data_req.wdata = wdata;
        data_req.len   = 4'd0;
        while (!got_last) begin
            @(negedge clk);
            if (data_rsp.data_ok) begin
                check_eq(32'(got_addr), 32'd1, "data_ok before addr_ok on data port");
                rdata    = data_rsp.rdata;
                got_last = data_rsp.last;
                beats++;
            end
            if (data_rsp.addr_ok) begin
                got_addr         = 1'b1;
                last_winner_data = 1'b1;
            end
            @(posedge clk);
            #2;
            if (got_addr) data_req = '0;
        end
        check_eq(32'(beats), 32'd1, "data port beat count");
    endtask

    task automatic data_write(input mem_req_pkg::size_e size, input logic [31:0] addr,
                              input logic [31:0] wdata);
        logic [31:0] unused_rdata;
        data_access(1'b1, size, addr, wdata, unused_rdata);
        model_write(size, addr, wdata);
    endtask

    task automatic data_read(input mem_req_pkg::size_e size, input logic [31:0] addr,
                             output logic [31:0] rdata);
        data_access(1'b0, size, addr, 32'd0, rdata);
    endtask

    task automatic data_op(input logic wr, input mem_req_pkg::size_e size,
                           input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        if (wr) begin
            data_write(size, addr, wdata);
        end else begin
            data_read(size, addr, rdata);
            check_eq(rdata, ref_mem[model_index(addr)], "data read value");
        end
    endtask

    // burst read on the instruction port, each beat checked against the model
    task automatic inst_burst_read(input logic [31:0] addr, input logic [3:0] len);
        logic got_addr;
        logic got_last;
        int   beats;
        got_addr = 1'b0;
        got_last = 1'b0;
        beats    = 0;
        inst_req      = '0;
        inst_req.req  = 1'b1;
        inst_req.size = mem_req_pkg::size_word;
        inst_req.addr = addr;
        inst_req.len  = len;
        while (!got_last) begin
            @(negedge clk);
            if (inst_rsp.data_ok) begin
                check_eq(32'(got_addr), 32'd1, "data_ok before addr_ok on inst port");
                check_eq(inst_rsp.rdata, ref_mem[model_index(addr + 32'(4 * beats))],
                         "inst burst data");
                check_eq(32'(inst_rsp.last), 32'(beats == int'(len)), "inst burst last flag");
                got_last = inst_rsp.last;
                beats++;
            end
            if (inst_rsp.addr_ok) begin
                got_addr         = 1'b1;
                last_winner_data = 1'b0;
            end
            @(posedge clk);
            #2;
            if (got_addr) inst_req = '0;
        end
        check_eq(32'(beats), 32'(len) + 32'd1, "inst burst beat count");
    endtask

    // both ports request in the same cycle
    task automatic concurrent_pair(input logic [31:0] inst_addr, input logic [3:0] inst_len,
                                   input logic wr, input mem_req_pkg::size_e size,
                                   input logic [31:0] addr, input logic [31:0] wdata);
        int   inst_start;
        int   data_start;
        logic first_data;
        // the port that lost the last grant wins the tie
        first_data = !last_winner_data;
        inst_start = inst_beats;
        data_start = data_beats;
        grant_log.delete();
        fork
            inst_burst_read(inst_addr, inst_len);
            data_op(wr, size, addr, wdata);
        join
        check_eq(32'(grant_log.size()), 32'd2, "grant count in concurrent pair");
        check_eq(32'(grant_log[0]), 32'(first_data), "round-robin winner");
        check_eq(32'(inst_beats - inst_start), 32'(inst_len) + 32'd1, "inst port beats");
        check_eq(32'(data_beats - data_start), 32'd1, "data port beats");
    endtask

    task automatic reset_and_word_round_trip();
        logic [31:0] rdata;
        rst_n = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #2;
            check_flags_low("response flag during reset");
        end
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_flags_low("response flag after reset");
        data_write(mem_req_pkg::size_word, 32'h0000_0010, 32'hdead_beef);
        data_read(mem_req_pkg::size_word, 32'h0000_0010, rdata);
        check_eq(rdata, ref_mem[model_index(32'h0000_0010)], "word round trip");
    endtask

    task automatic partial_writes();
        logic [31:0] rdata;
        data_write(mem_req_pkg::size_word, 32'h0000_0020, 32'h1122_3344);
        data_write(mem_req_pkg::size_byte, 32'h0000_0021, 32'h0000_aa00);
        data_write(mem_req_pkg::size_byte, 32'h0000_0023, 32'hbb00_0000);
        data_write(mem_req_pkg::size_half, 32'h0000_0020, 32'h0000_ccdd);
        data_read(mem_req_pkg::size_word, 32'h0000_0020, rdata);
        check_eq(rdata, ref_mem[model_index(32'h0000_0020)], "partial write merge");
    endtask

    task automatic inst_burst_after_fill();
        logic [31:0] addr;
        for (int i = 0; i < 8; i++) begin
            addr = 32'h0000_0100 + 32'(4 * i);
            data_write(mem_req_pkg::size_word, addr, fill_word(addr));
        end
        inst_burst_read(32'h0000_0100, 4'd7);
    endtask

    task automatic concurrent_requesters();
        logic [31:0] rdata;
        concurrent_pair(32'h0000_0100, 4'd3, 1'b1, mem_req_pkg::size_word,
                        32'h0000_0040, 32'h5555_aaaa);
        data_read(mem_req_pkg::size_word, 32'h0000_0040, rdata);
        check_eq(rdata, ref_mem[model_index(32'h0000_0040)], "write from concurrent pair");
    endtask

    task automatic random_sequence();
        logic [31:0]        r;
        logic [31:0]        addr;
        logic [31:0]        wdata;
        logic [1:0]         offset;
        mem_req_pkg::size_e size;
        for (int i = 0; i < 16; i++) begin
            addr = rand_base + 32'(4 * i);
            data_write(mem_req_pkg::size_word, addr, fill_word(addr));
        end
        for (int i = 0; i < 40; i++) begin
            r     = $random(seed);
            wdata = $random(seed);
            case (r[2:1])
                2'd0: begin
                    size   = mem_req_pkg::size_byte;
                    offset = r[10:9];
                end
                2'd1: begin
                    size   = mem_req_pkg::size_half;
                    offset = {r[9], 1'b0};
                end
                default: begin
                    size   = mem_req_pkg::size_word;
                    offset = 2'd0;
                end
            endcase
            addr      = rand_base | {26'd0, r[6:3], 2'b00};
            addr[1:0] = offset;
            if (i % 10 == 9) begin
                concurrent_pair(rand_base | {26'd0, r[8:7], 4'b0000}, 4'd3,
                                r[0], size, addr, wdata);
            end else begin
                data_op(r[0], size, addr, wdata);
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        inst_req = '0;
        data_req = '0;
        reset_and_word_round_trip();
        partial_writes();
        inst_burst_after_fill();
        concurrent_requesters();
        random_sequence();
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles, a transaction never completed",
                 watchdog_cycles);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- cpu_axi_subsys.f
hw/mem_req_pkg.sv
hw/axi_pkg.sv
hw/sramlike_arbiter.sv
hw/sramlike_to_axi.sv
hw/axi_sram.sv
hw/cpu_axi_subsys.sv
tb/tb_clock_gen.sv
tb/cpu_axi_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= cpu_axi_subsys_tb
FILELIST  ?= cpu_axi_subsys.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
